/* verilog/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] word_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_branch = 7'b1100011
    } opcode_e;

    // funct3 order, sra and sub take the slt and sltu slots
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_e;

    // branch funct3 encoding
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    // 2'b10 is free, there is no memory stage to forward from
    typedef enum logic [1:0] {
        fwd_rf  = 2'b00,
        fwd_exe = 2'b01,
        fwd_wb  = 2'b11
    } fwd_sel_e;

    typedef enum logic {
        alumux1_rs1 = 1'b0,
        alumux1_pc  = 1'b1
    } alumux1_sel_e;

    typedef enum logic [2:0] {
        alumux2_i   = 3'd0,
        alumux2_u   = 3'd1,
        alumux2_b   = 3'd2,
        alumux2_s   = 3'd3,
        alumux2_j   = 3'd4,
        alumux2_rs2 = 3'd5
    } alumux2_sel_e;

    typedef enum logic {
        cmpmux_rs2 = 1'b0,
        cmpmux_i   = 1'b1
    } cmpmux_sel_e;

    typedef enum logic {
        rd_alu = 1'b0,
        rd_cmp = 1'b1
    } rd_src_e;

    typedef struct packed {
        word_t i_imm;
        word_t s_imm;
        word_t b_imm;
        word_t u_imm;
        word_t j_imm;
    } imm_t;

    typedef struct packed {
        logic         valid;
        word_t        pc;
        logic [4:0]   rd;
        logic         rd_we;
        logic         illegal;
        logic         br;
        alu_op_e      aluop;
        cmp_op_e      cmpop;
        alumux1_sel_e alumux1_sel;
        alumux2_sel_e alumux2_sel;
        cmpmux_sel_e  cmpmux_sel;
        rd_src_e      rd_src;
        fwd_sel_e     rs1_sel;
        fwd_sel_e     rs2_sel;
        word_t        rs1_data;
        word_t        rs2_data;
        imm_t         imm;
    } id_ex_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        logic [4:0] rd;
        logic       rd_we;
        word_t      value;
        logic       br;
        logic       br_taken;
        word_t      br_target;
        logic       illegal;
    } retire_t;

endpackage

`default_nettype wire

/* verilog/regfile.sv */
`default_nettype none

module regfile (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [4:0]             rs1_addr_i,
    input  wire [4:0]             rs2_addr_i,
    output rv32i_pkg::word_t      rs1_data_o,
    output rv32i_pkg::word_t      rs2_data_o,
    input  wire                   we_i,
    input  wire [4:0]             rd_i,
    input  wire rv32i_pkg::word_t wd_i
);

    rv32i_pkg::word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != 5'd0)) begin
            regs[rd_i] <= wd_i;
        end
    end

    // x0 always reads zero
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu (
    input  wire rv32i_pkg::alu_op_e aluop_i,
    input  wire rv32i_pkg::word_t   a_i,
    input  wire rv32i_pkg::word_t   b_i,
    output rv32i_pkg::word_t        f_o
);

    logic [4:0] shamt;

    // shifts only look at the low five bits
    assign shamt = b_i[4:0];

    always_comb begin
        unique case (aluop_i)
            rv32i_pkg::alu_add: f_o = a_i + b_i;
            rv32i_pkg::alu_sub: f_o = a_i - b_i;
            rv32i_pkg::alu_sll: f_o = a_i << shamt;
            rv32i_pkg::alu_srl: f_o = a_i >> shamt;
            rv32i_pkg::alu_sra: f_o = $signed(a_i) >>> shamt;
            rv32i_pkg::alu_xor: f_o = a_i ^ b_i;
            rv32i_pkg::alu_or:  f_o = a_i | b_i;
            rv32i_pkg::alu_and: f_o = a_i & b_i;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`default_nettype none

module decode_stage #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cyc_i,
    input  wire                     stb_i,
    input  wire                     we_i,
    input  wire rv32i_pkg::word_t   dat_i,
    output rv32i_pkg::word_t        dat_o,
    output logic                    ack_o,
    output logic [4:0]              rs1_addr_o,
    output logic [4:0]              rs2_addr_o,
    input  wire rv32i_pkg::word_t   rs1_data_i,
    input  wire rv32i_pkg::word_t   rs2_data_i,
    input  wire rv32i_pkg::retire_t retiring_i,
    output rv32i_pkg::id_ex_t       id_ex_o
);

    rv32i_pkg::word_t   pc_cnt;
    rv32i_pkg::word_t   instr_q;
    rv32i_pkg::word_t   pc_q;
    logic               valid_q;
    rv32i_pkg::opcode_e opcode;
    logic [2:0]         funct3;
    logic               alt_f;
    rv32i_pkg::alu_op_e alu_fn;
    rv32i_pkg::imm_t    imm;
    rv32i_pkg::id_ex_t  id_ex_d;

    // zero wait states, every addressed cycle is acknowledged at once
    assign ack_o = cyc_i & stb_i & ~rst;
    // a read returns the pc the next word will get
    assign dat_o = pc_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_cnt  <= RESET_PC;
            valid_q <= 1'b0;
        end else begin
            valid_q <= ack_o & we_i;
            if (ack_o && we_i) begin
                pc_cnt <= pc_cnt + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ack_o && we_i) begin
            instr_q <= dat_i;
            pc_q    <= pc_cnt;
        end
    end

    assign opcode = rv32i_pkg::opcode_e'(instr_q[6:0]);
    assign funct3 = instr_q[14:12];
    assign alt_f  = instr_q[30];

    assign imm.i_imm = {{21{instr_q[31]}}, instr_q[30:20]};
    assign imm.s_imm = {{21{instr_q[31]}}, instr_q[30:25], instr_q[11:7]};
    assign imm.b_imm = {{20{instr_q[31]}}, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};
    assign imm.u_imm = {instr_q[31:12], 12'h000};
    assign imm.j_imm = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};

    // lui reads x0 so the alu adds its immediate to zero
    assign rs1_addr_o = (opcode == rv32i_pkg::opc_lui) ? 5'd0 : instr_q[19:15];
    assign rs2_addr_o = instr_q[24:20];

    // newest producer wins, execute before retire
    function automatic rv32i_pkg::fwd_sel_e fwd_select(
        input logic [4:0]         src,
        input rv32i_pkg::id_ex_t  exe,
        input rv32i_pkg::retire_t ret
    );
        rv32i_pkg::fwd_sel_e sel;
        sel = rv32i_pkg::fwd_rf;
        if (src != 5'd0) begin
            if (exe.valid && exe.rd_we && (exe.rd == src)) begin
                sel = rv32i_pkg::fwd_exe;
            end else if (ret.valid && ret.rd_we && (ret.rd == src)) begin
                sel = rv32i_pkg::fwd_wb;
            end
        end
        return sel;
    endfunction

    always_comb begin
        case (funct3)
            3'b001: alu_fn = rv32i_pkg::alu_sll;
            3'b100: alu_fn = rv32i_pkg::alu_xor;
            3'b101: begin
                if (alt_f) begin
                    alu_fn = rv32i_pkg::alu_sra;
                end else begin
                    alu_fn = rv32i_pkg::alu_srl;
                end
            end
            3'b110: alu_fn = rv32i_pkg::alu_or;
            3'b111: alu_fn = rv32i_pkg::alu_and;
            default: begin
                // sub only exists in the register-register form
                if ((opcode == rv32i_pkg::opc_op) && alt_f) begin
                    alu_fn = rv32i_pkg::alu_sub;
                end else begin
                    alu_fn = rv32i_pkg::alu_add;
                end
            end
        endcase
    end

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.valid    = valid_q;
        id_ex_d.pc       = pc_q;
        id_ex_d.rd       = instr_q[11:7];
        id_ex_d.imm      = imm;
        id_ex_d.rs1_data = rs1_data_i;
        id_ex_d.rs2_data = rs2_data_i;
        id_ex_d.rs1_sel  = fwd_select(rs1_addr_o, id_ex_o, retiring_i);
        id_ex_d.rs2_sel  = fwd_select(rs2_addr_o, id_ex_o, retiring_i);

        case (opcode)
            rv32i_pkg::opc_op, rv32i_pkg::opc_op_imm: begin
                id_ex_d.aluop = alu_fn;
                if (opcode == rv32i_pkg::opc_op) begin
                    id_ex_d.alumux2_sel = rv32i_pkg::alumux2_rs2;
                end else begin
                    id_ex_d.alumux2_sel = rv32i_pkg::alumux2_i;
                    id_ex_d.cmpmux_sel  = rv32i_pkg::cmpmux_i;
                end
                // slt -> blt, sltu -> bltu
                if (funct3[2:1] == 2'b01) begin
                    id_ex_d.rd_src = rv32i_pkg::rd_cmp;
                    id_ex_d.cmpop  = rv32i_pkg::cmp_op_e'({1'b1, funct3[0], 1'b0});
                end
            end
            rv32i_pkg::opc_lui: begin
                id_ex_d.alumux2_sel = rv32i_pkg::alumux2_u;
            end
            rv32i_pkg::opc_auipc: begin
                id_ex_d.alumux1_sel = rv32i_pkg::alumux1_pc;
                id_ex_d.alumux2_sel = rv32i_pkg::alumux2_u;
            end
            rv32i_pkg::opc_branch: begin
                id_ex_d.br          = 1'b1;
                id_ex_d.cmpop       = rv32i_pkg::cmp_op_e'(funct3);
                id_ex_d.alumux1_sel = rv32i_pkg::alumux1_pc;
                id_ex_d.alumux2_sel = rv32i_pkg::alumux2_b;
                id_ex_d.illegal     = (funct3[2:1] == 2'b01);
            end
            default: id_ex_d.illegal = 1'b1;
        endcase

        id_ex_d.rd_we = valid_q & ~id_ex_d.illegal & ~id_ex_d.br & (id_ex_d.rd != 5'd0);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

/* verilog/exe_stage.sv */
`default_nettype none

module exe_stage (
    input  wire                    clk,
    input  wire                    rst,
    input  wire rv32i_pkg::id_ex_t id_ex_i,
    input  wire rv32i_pkg::word_t  wb_fwd_i,
    output rv32i_pkg::retire_t     retire_o
);

    rv32i_pkg::word_t exe_fwd;
    rv32i_pkg::word_t rs1_o;
    rv32i_pkg::word_t rs2_o;
    rv32i_pkg::word_t alumux1_o;
    rv32i_pkg::word_t alumux2_o;
    rv32i_pkg::word_t cmpmux_o;
    rv32i_pkg::word_t alu_f;
    rv32i_pkg::word_t rd_value;
    logic             cmp_flag;

    // result of the previous instruction, still in our own output register
    assign exe_fwd = retire_o.value;

    alu i_alu (
        .aluop_i (id_ex_i.aluop),
        .a_i     (alumux1_o),
        .b_i     (alumux2_o),
        .f_o     (alu_f)
    );

    always_comb begin : exe_mux
        case (id_ex_i.rs1_sel)
            rv32i_pkg::fwd_exe: rs1_o = exe_fwd;
            rv32i_pkg::fwd_wb:  rs1_o = wb_fwd_i;
            default:            rs1_o = id_ex_i.rs1_data;
        endcase

        case (id_ex_i.rs2_sel)
            rv32i_pkg::fwd_exe: rs2_o = exe_fwd;
            rv32i_pkg::fwd_wb:  rs2_o = wb_fwd_i;
            default:            rs2_o = id_ex_i.rs2_data;
        endcase

        case (id_ex_i.cmpmux_sel)
            rv32i_pkg::cmpmux_i: cmpmux_o = id_ex_i.imm.i_imm;
            default:             cmpmux_o = rs2_o;
        endcase

        case (id_ex_i.alumux1_sel)
            rv32i_pkg::alumux1_pc: alumux1_o = id_ex_i.pc;
            default:               alumux1_o = rs1_o;
        endcase

        case (id_ex_i.alumux2_sel)
            rv32i_pkg::alumux2_i: alumux2_o = id_ex_i.imm.i_imm;
            rv32i_pkg::alumux2_u: alumux2_o = id_ex_i.imm.u_imm;
            rv32i_pkg::alumux2_b: alumux2_o = id_ex_i.imm.b_imm;
            rv32i_pkg::alumux2_s: alumux2_o = id_ex_i.imm.s_imm;
            rv32i_pkg::alumux2_j: alumux2_o = id_ex_i.imm.j_imm;
            default:              alumux2_o = rs2_o;
        endcase
    end

    always_comb begin : comparator
        case (id_ex_i.cmpop)
            rv32i_pkg::cmp_beq:  cmp_flag = (rs1_o == cmpmux_o);
            rv32i_pkg::cmp_bne:  cmp_flag = (rs1_o != cmpmux_o);
            rv32i_pkg::cmp_blt:  cmp_flag = ($signed(rs1_o) < $signed(cmpmux_o));
            rv32i_pkg::cmp_bge:  cmp_flag = ($signed(rs1_o) >= $signed(cmpmux_o));
            rv32i_pkg::cmp_bltu: cmp_flag = (rs1_o < cmpmux_o);
            rv32i_pkg::cmp_bgeu: cmp_flag = (rs1_o >= cmpmux_o);
            default:             cmp_flag = 1'b0;
        endcase
    end

    assign rd_value = (id_ex_i.rd_src == rv32i_pkg::rd_cmp) ? {31'b0, cmp_flag} : alu_f;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_o <= '0;
        end else begin
            retire_o.valid     <= id_ex_i.valid;
            retire_o.pc        <= id_ex_i.pc;
            retire_o.rd        <= id_ex_i.rd;
            retire_o.rd_we     <= id_ex_i.rd_we;
            retire_o.value     <= rd_value;
            retire_o.br        <= id_ex_i.br;
            retire_o.br_taken  <= id_ex_i.br & cmp_flag;
            // a branch sets the alu up for pc + b-immediate
            retire_o.br_target <= alu_f;
            retire_o.illegal   <= id_ex_i.illegal;
        end
    end

endmodule

`default_nettype wire

/* verilog/writeback_stage.sv */
`default_nettype none

module writeback_stage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire rv32i_pkg::retire_t retire_i,
    output logic                    rf_we_o,
    output logic [4:0]              rf_rd_o,
    output rv32i_pkg::word_t        rf_wd_o,
    output rv32i_pkg::word_t        wb_fwd_o,
    output rv32i_pkg::retire_t      retire_o
);

    assign rf_we_o  = retire_i.valid & retire_i.rd_we;
    assign rf_rd_o  = retire_i.rd;
    assign rf_wd_o  = retire_i.value;
    assign retire_o = retire_i;

    // decode read the register file before this write landed,
    // so the value is kept one more cycle for the fwd_wb path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_fwd_o <= '0;
        end else if (rf_we_o) begin
            wb_fwd_o <= retire_i.value;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv32i_pipe_top.sv */
`default_nettype none

module rv32i_pipe_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   cyc_i,
    input  wire                   stb_i,
    input  wire                   we_i,
    input  wire rv32i_pkg::word_t dat_i,
    output rv32i_pkg::word_t      dat_o,
    output logic                  ack_o,
    output rv32i_pkg::retire_t    retire_o
);

    logic [4:0]         rs1_addr;
    logic [4:0]         rs2_addr;
    rv32i_pkg::word_t   rs1_data;
    rv32i_pkg::word_t   rs2_data;
    logic               rf_we;
    logic [4:0]         rf_rd;
    rv32i_pkg::word_t   rf_wd;
    rv32i_pkg::word_t   wb_fwd;
    rv32i_pkg::id_ex_t  id_ex;
    rv32i_pkg::retire_t exe_retire;

    decode_stage #(
        .RESET_PC (RESET_PC)
    ) i_decode_stage (
        .clk        (clk),
        .rst        (rst),
        .cyc_i      (cyc_i),
        .stb_i      (stb_i),
        .we_i       (we_i),
        .dat_i      (dat_i),
        .dat_o      (dat_o),
        .ack_o      (ack_o),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .retiring_i (retire_o),
        .id_ex_o    (id_ex)
    );

    exe_stage i_exe_stage (
        .clk      (clk),
        .rst      (rst),
        .id_ex_i  (id_ex),
        .wb_fwd_i (wb_fwd),
        .retire_o (exe_retire)
    );

    writeback_stage i_writeback_stage (
        .clk      (clk),
        .rst      (rst),
        .retire_i (exe_retire),
        .rf_we_o  (rf_we),
        .rf_rd_o  (rf_rd),
        .rf_wd_o  (rf_wd),
        .wb_fwd_o (wb_fwd),
        .retire_o (retire_o)
    );

    regfile i_regfile (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_i       (rf_rd),
        .wd_i       (rf_wd)
    );

endmodule

`default_nettype wire

/* dv/rv32i_pipe_assert.sv */
`default_nettype none

module rv32i_pipe_assert (
    input wire                     clk,
    input wire                     rst,
    input wire                     cyc_i,
    input wire                     stb_i,
    input wire                     we_i,
    input wire rv32i_pkg::word_t   dat_o,
    input wire                     ack_o,
    input wire rv32i_pkg::retire_t retire_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // every write cycle is taken at once and moves the pc by one word
    a_write_taken: assert property (@(posedge clk) disable iff (rst)
        (cyc_i && stb_i && we_i) |=> (dat_o == $past(dat_o) + 32'd4))
        else $error("write cycle did not advance the pc by four");

    // record is loaded two edges after the accepting edge, seen at the third sample
    a_retire_follows: assert property (@(posedge clk) disable iff (rst)
        (ack_o && we_i) |-> ##3 retire_o.valid)
        else $error("accepted word did not retire two edges later");

    a_retire_has_word: assert property (@(posedge clk) disable iff (rst)
        retire_o.valid |-> $past(ack_o && we_i, 3))
        else $error("retire record without an accepted word");

    a_no_write: assert property (@(posedge clk) disable iff (rst)
        (retire_o.valid && ((retire_o.rd == 5'd0) || retire_o.illegal)) |-> !retire_o.rd_we)
        else $error("rd_we set for x0 or an illegal word");

endmodule

bind rv32i_pipe_top rv32i_pipe_assert i_rv32i_pipe_assert (
    .clk      (clk),
    .rst      (rst),
    .cyc_i    (cyc_i),
    .stb_i    (stb_i),
    .we_i     (we_i),
    .dat_o    (dat_o),
    .ack_o    (ack_o),
    .retire_o (retire_o)
);

`default_nettype wire

/* dv/rv32i_pipe_tb.sv */
`default_nettype none

module rv32i_pipe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RESET_PC = 32'h0000_1000;
    localparam int TIMEOUT = 50;

    // one program word with the architectural result it must retire
    typedef struct packed {
        logic [31:0] word;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] value;
        logic        br;
        logic        taken;
        logic [31:0] target;
        logic        illegal;
    } entry_t;

    logic               clk;
    logic               rst;
    logic               cyc;
    logic               stb;
    logic               we;
    logic [31:0]        dat_w;
    rv32i_pkg::word_t   dat_r;
    logic               ack;
    rv32i_pkg::retire_t retire;

    entry_t      tbl[$];
    logic [31:0] mregs [32];
    int          mon_idx;
    int          passes;
    int          errors;
    int          seed;

    rv32i_pipe_top #(
        .RESET_PC (RESET_PC)
    ) i_rv32i_pipe_top (
        .clk      (clk),
        .rst      (rst),
        .cyc_i    (cyc),
        .stb_i    (stb),
        .we_i     (we),
        .dat_i    (dat_w),
        .dat_o    (dat_r),
        .ack_o    (ack),
        .retire_o (retire)
    );

    always #5 clk = ~clk;

    // instruction encoders
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                          logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_u(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    // RV32I arithmetic semantics, alt is instruction bit 30 where it applies
    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(b)};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // reference model, run in program order since forwarding hides all hazards
    task automatic add_instr(input logic [31:0] w);
        entry_t      e;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immi;
        logic [31:0] immb;
        logic [2:0]  f3;
        pc = RESET_PC + 32'(4 * tbl.size());
        e = '0;
        e.word = w;
        e.rd = w[11:7];
        f3 = w[14:12];
        a = mregs[w[19:15]];
        b = mregs[w[24:20]];
        immi = {{20{w[31]}}, w[31:20]};
        immb = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        case (w[6:0])
            7'h33: e.value = alu_ref(f3, w[30], a, b);
            7'h13: e.value = alu_ref(f3, w[30] && (f3 == 3'd5), a, immi);
            7'h37: e.value = {w[31:12], 12'h000};
            7'h17: e.value = pc + {w[31:12], 12'h000};
            7'h63: begin
                e.br = 1'b1;
                e.taken = branch_ref(f3, a, b);
                e.target = pc + immb;
            end
            default: e.illegal = 1'b1;
        endcase
        e.we = !e.br && !e.illegal && (e.rd != 5'd0);
        if (e.we) begin
            mregs[e.rd] = e.value;
        end
        tbl.push_back(e);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout bit bad);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            bad = 1'b1;
        end
    endtask

    task automatic end_on_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic bus_cycle(input logic write, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waited;
        waited = 0;
        cyc = 1'b1;
        stb = 1'b1;
        we = write;
        dat_w = wdata;
        @(posedge clk);
        while (!ack) begin
            if (waited >= TIMEOUT) begin
                end_on_timeout("bus acknowledge");
            end
            waited++;
            @(posedge clk);
        end
        rdata = dat_r;
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic read_check(input string what, input logic [31:0] exp);
        logic [31:0] rdata;
        bus_cycle(1'b0, '0, rdata);
        if (rdata !== exp) begin
            $display("CHECK FAILED at %0t ns: dat_o got %h expected %h", $time, rdata, exp);
            $display("%s: FAILED", what);
            errors++;
        end else begin
            $display("%s: ok", what);
            passes++;
        end
    endtask

    // compare every valid retire record against the next table entry
    always @(negedge clk) begin
        bit     bad;
        entry_t e;
        bad = 1'b0;
        if (!rst && retire.valid) begin
            if (mon_idx >= tbl.size()) begin
                $display("unexpected retire record at %0t ns, pc %h", $time, retire.pc);
                errors++;
            end else begin
                e = tbl[mon_idx];
                check_field("retire_o.pc", retire.pc, RESET_PC + 32'(4 * mon_idx), bad);
                check_field("retire_o.rd_we", 32'(retire.rd_we), 32'(e.we), bad);
                check_field("retire_o.illegal", 32'(retire.illegal), 32'(e.illegal), bad);
                check_field("retire_o.br", 32'(retire.br), 32'(e.br), bad);
                check_field("retire_o.br_taken", 32'(retire.br_taken), 32'(e.taken), bad);
                if (e.we) begin
                    check_field("retire_o.rd", 32'(retire.rd), 32'(e.rd), bad);
                    check_field("retire_o.value", retire.value, e.value, bad);
                end
                if (e.br) begin
                    check_field("retire_o.br_target", retire.br_target, e.target, bad);
                end
                if (bad) begin
                    $display("test %0d word %h: FAILED", mon_idx, e.word);
                    errors++;
                end else begin
                    $display("test %0d word %h: ok", mon_idx, e.word);
                    passes++;
                end
                mon_idx++;
            end
        end
    end

    initial begin
        logic [31:0] unused_rdata;
        int          gap;
        int          waited;
        bit          reset_bad;
        clk = 1'b0;
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        dat_w = '0;
        seed = 32'h6ef5;
        mon_idx = 0;
        passes = 0;
        errors = 0;
        reset_bad = 1'b0;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = '0;
        end

        // operand setup and every OP / OP_IMM function
        add_instr(enc_u(7'h37, 5'd1, 20'h80000));
        add_instr(enc_i(3'd0, 5'd1, 5'd1, 12'd5));
        add_instr(enc_i(3'd0, 5'd2, 5'd0, 12'hffd));
        add_instr(enc_i(3'd0, 5'd3, 5'd0, 12'd7));
        add_instr(enc_r(7'h00, 3'd0, 5'd4, 5'd1, 5'd3));
        add_instr(enc_r(7'h20, 3'd0, 5'd5, 5'd3, 5'd2));
        add_instr(enc_r(7'h00, 3'd1, 5'd6, 5'd3, 5'd3));
        add_instr(enc_r(7'h00, 3'd2, 5'd7, 5'd2, 5'd3));
        add_instr(enc_r(7'h00, 3'd3, 5'd8, 5'd2, 5'd3));
        add_instr(enc_r(7'h00, 3'd4, 5'd9, 5'd1, 5'd2));
        add_instr(enc_r(7'h00, 3'd5, 5'd10, 5'd2, 5'd3));
        add_instr(enc_r(7'h20, 3'd5, 5'd11, 5'd2, 5'd3));
        add_instr(enc_r(7'h00, 3'd6, 5'd12, 5'd9, 5'd3));
        add_instr(enc_r(7'h00, 3'd7, 5'd13, 5'd12, 5'd1));
        add_instr(enc_i(3'd2, 5'd14, 5'd2, 12'hfff));
        add_instr(enc_i(3'd3, 5'd15, 5'd3, 12'hfff));
        add_instr(enc_i(3'd4, 5'd16, 5'd3, 12'hfff));
        add_instr(enc_i(3'd6, 5'd17, 5'd3, 12'h070));
        add_instr(enc_i(3'd7, 5'd18, 5'd1, 12'h0ff));
        add_instr(enc_i(3'd1, 5'd19, 5'd3, 12'h01c));
        add_instr(enc_i(3'd5, 5'd20, 5'd1, 12'h004));
        add_instr(enc_i(3'd5, 5'd21, 5'd1, 12'h404));
        // upper immediates against the counted pc
        add_instr(enc_u(7'h17, 5'd22, 20'h12345));
        add_instr(enc_i(3'd0, 5'd23, 5'd22, 12'd1));
        // all six branch conditions
        add_instr(enc_b(3'd0, 5'd3, 5'd3, 13'd8));
        add_instr(enc_b(3'd1, 5'd3, 5'd3, 13'h1ff0));
        add_instr(enc_b(3'd4, 5'd2, 5'd3, 13'd16));
        add_instr(enc_b(3'd6, 5'd2, 5'd3, 13'd16));
        add_instr(enc_b(3'd5, 5'd1, 5'd2, 13'h1ffc));
        add_instr(enc_b(3'd7, 5'd2, 5'd1, 13'd32));
        // x0 stays zero, an illegal word changes nothing
        add_instr(enc_i(3'd0, 5'd0, 5'd3, 12'd9));
        add_instr(enc_r(7'h00, 3'd0, 5'd24, 5'd0, 5'd3));
        add_instr(32'hffff_ffff);
        add_instr(enc_i(3'd0, 5'd25, 5'd31, 12'd0));
        // older results reread from the register file
        add_instr(enc_r(7'h00, 3'd0, 5'd26, 5'd4, 5'd5));
        add_instr(enc_r(7'h00, 3'd4, 5'd27, 5'd7, 5'd15));

        repeat (4) @(posedge clk);
        // a write offered during reset must be neither acknowledged nor taken
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        dat_w = tbl[0].word;
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("CHECK FAILED at %0t ns: ack_o got %b expected 0", $time, ack);
            reset_bad = 1'b1;
        end
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        dat_w = '0;
        rst = 1'b0;
        @(negedge clk);
        if (retire.valid !== 1'b0) begin
            $display("CHECK FAILED at %0t ns: retire_o.valid got %b expected 0",
                     $time, retire.valid);
            reset_bad = 1'b1;
        end
        if (reset_bad) begin
            $display("reset state: FAILED");
            errors++;
        end else begin
            $display("reset state: ok");
            passes++;
        end
        read_check("pc read after reset", RESET_PC);

        for (int k = 0; k < tbl.size(); k++) begin
            bus_cycle(1'b1, tbl[k].word, unused_rdata);
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk);
        end
        read_check("pc read after program", RESET_PC + 32'(4 * tbl.size()));

        waited = 0;
        while (mon_idx < tbl.size()) begin
            if (waited >= TIMEOUT) begin
                end_on_timeout("retirement of the whole program");
            end
            waited++;
            @(negedge clk);
        end
        repeat (3) @(negedge clk);

        $display("passed %0d failed %0d", passes, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
verilog/rv32i_pkg.sv
verilog/regfile.sv
verilog/alu.sv
verilog/decode_stage.sv
verilog/exe_stage.sv
verilog/writeback_stage.sv
verilog/rv32i_pipe_top.sv
dv/rv32i_pipe_assert.sv
dv/rv32i_pipe_tb.sv

/* Makefile */
SIM := obj_dir/sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module rv32i_pipe_tb \
		-f build.f -o sim
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
